//--- src/display_defines.svh
`ifndef DISPLAY_DEFINES_SVH
`define DISPLAY_DEFINES_SVH

`default_nettype none

// Command queue depth, also the host's starting credit count.
`define DISP_CMD_DEPTH 2
`define DISP_MAX_VALUE 6'd47
`define DISP_PRESCALE_W 16

// ********************
// Active-low segments, bit 0 is segment a, bit 6 is segment g.
`define DISP_SEG_D0    7'b1000000
`define DISP_SEG_D1    7'b1111001
`define DISP_SEG_D2    7'b0100100
`define DISP_SEG_D3    7'b0110000
`define DISP_SEG_D4    7'b0011001
`define DISP_SEG_D5    7'b0010010
`define DISP_SEG_D6    7'b0000010
`define DISP_SEG_D7    7'b1011000
`define DISP_SEG_D8    7'b0000000
`define DISP_SEG_D9    7'b0010000
`define DISP_SEG_BLANK 7'b1111111

`default_nettype wire

`endif

//--- src/display_pkg.sv
`include "display_defines.svh"
`default_nettype none

package display_pkg;

  // Five opcodes need three bits.
  typedef enum logic [2:0] {
    SET_LIMIT    = 3'd0,
    SET_PRESCALE = 3'd1,
    RUN          = 3'd2,
    STOP         = 3'd3,
    CLEAR        = 3'd4
  } cmd_op_e;

  typedef struct packed {
    logic [`DISP_PRESCALE_W-7:0] pad;
    logic [5:0]                  limit;
  } limit_view_t;

  // One payload word, read as a limit or as a prescale divisor.
  typedef union packed {
    limit_view_t                 lim;
    logic [`DISP_PRESCALE_W-1:0] prescale;
  } cmd_payload_u;

  typedef struct packed {
    cmd_op_e      op;
    cmd_payload_u payload;
  } disp_cmd_t;

  typedef struct packed {
    logic [6:0] tens;
    logic [6:0] ones;
  } seg_pair_t;

endpackage

`default_nettype wire

//--- src/seven_hex_decoder.sv
`include "display_defines.svh"
`default_nettype none

// Digit layout, a dark segment is 1.
//     a
//   f   b
//     g
//   e   c
//     d
module seven_hex_decoder (
  input  wire logic [5:0]            i_value,
  output display_pkg::seg_pair_t     o_segments
);

  logic [3:0] tens;
  logic [5:0] tens_base;
  logic [3:0] ones;

  function automatic logic [6:0] digit_segments(input logic [3:0] digit);
    case (digit)
      4'd0:    return `DISP_SEG_D0;
      4'd1:    return `DISP_SEG_D1;
      4'd2:    return `DISP_SEG_D2;
      4'd3:    return `DISP_SEG_D3;
      4'd4:    return `DISP_SEG_D4;
      4'd5:    return `DISP_SEG_D5;
      4'd6:    return `DISP_SEG_D6;
      4'd7:    return `DISP_SEG_D7;
      4'd8:    return `DISP_SEG_D8;
      4'd9:    return `DISP_SEG_D9;
      default: return `DISP_SEG_BLANK;
    endcase
  endfunction

  // ********************
  // Split into tens and ones.
  always_comb begin
    if (i_value >= 6'd40) begin
      tens      = 4'd4;
      tens_base = 6'd40;
    end else if (i_value >= 6'd30) begin
      tens      = 4'd3;
      tens_base = 6'd30;
    end else if (i_value >= 6'd20) begin
      tens      = 4'd2;
      tens_base = 6'd20;
    end else if (i_value >= 6'd10) begin
      tens      = 4'd1;
      tens_base = 6'd10;
    end else begin
      tens      = 4'd0;
      tens_base = 6'd0;
    end
    ones = 4'(i_value - tens_base);
  end

  // Out of range shows two dark digits.
  always_comb begin
    if (i_value > `DISP_MAX_VALUE) begin
      o_segments.tens = `DISP_SEG_BLANK;
      o_segments.ones = `DISP_SEG_BLANK;
    end else begin
      o_segments.tens = digit_segments(tens);
      o_segments.ones = digit_segments(ones);
    end
  end

endmodule

`default_nettype wire

//--- src/counter_config_regs.sv
`include "display_defines.svh"
`default_nettype none

module counter_config_regs (
  input  wire logic                        i_clk,
  input  wire logic                        i_reset,
  input  wire logic                        i_cmd_valid,
  input  wire display_pkg::disp_cmd_t      i_cmd,
  output logic                             o_credit,
  output logic [5:0]                       o_limit,
  output logic [`DISP_PRESCALE_W-1:0]      o_prescale,
  output logic                             o_run,
  output logic                             o_clear
);
  import display_pkg::*;

  localparam int PTR_W = $clog2(`DISP_CMD_DEPTH);
  localparam int CNT_W = $clog2(`DISP_CMD_DEPTH + 1);

  disp_cmd_t        queue [`DISP_CMD_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill_count;
  logic             pop;
  disp_cmd_t        head;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`DISP_CMD_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  function automatic logic [5:0] clamp_limit(input logic [5:0] limit);
    return (limit > `DISP_MAX_VALUE) ? `DISP_MAX_VALUE : limit;
  endfunction

  // ********************
  // Credit queue. The host never sends without a credit.
  assign pop  = (fill_count != '0);
  assign head = queue[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_cmd_valid) begin
      queue[wr_ptr] <= i_cmd;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
    end else begin
      if (i_cmd_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({i_cmd_valid, pop})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: fill_count <= fill_count;
      endcase
    end
  end

  // ********************
  // Apply the head command.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_credit   <= 1'b0;
      o_clear    <= 1'b0;
      o_run      <= 1'b0;
      o_limit    <= `DISP_MAX_VALUE;
      o_prescale <= '0;
    end else begin
      o_credit <= pop;
      o_clear  <= 1'b0;
      if (pop) begin
        case (head.op)
          SET_LIMIT:    o_limit    <= clamp_limit(head.payload.lim.limit);
          SET_PRESCALE: o_prescale <= head.payload.prescale;
          RUN:          o_run      <= 1'b1;
          STOP:         o_run      <= 1'b0;
          // Back-to-back clears merge into one pulse.
          CLEAR:        o_clear    <= ~o_clear;
          default:      o_run      <= o_run;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- src/tick_counter.sv
`include "display_defines.svh"
`default_nettype none

module tick_counter (
  input  wire logic                        i_clk,
  input  wire logic                        i_reset,
  input  wire logic [5:0]                  i_limit,
  input  wire logic [`DISP_PRESCALE_W-1:0] i_prescale,
  input  wire logic                        i_run,
  input  wire logic                        i_clear,
  output logic [5:0]                       o_value
);

  logic [`DISP_PRESCALE_W-1:0] prescale_count;
  logic                        step;
  logic [5:0]                  next_value;

  // A lowered prescale must not strand the count above it.
  assign step = i_run && (prescale_count >= i_prescale);

  // Wrap at the limit, or from above a freshly lowered one.
  assign next_value = (o_value >= i_limit) ? 6'd0 : o_value + 6'd1;

  // ********************
  // Prescaler.
  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      prescale_count <= '0;
    end else if (step) begin
      prescale_count <= '0;
    end else if (i_run) begin
      prescale_count <= prescale_count + 1'b1;
    end
  end

  // ********************
  // Value counter, clear wins over a step.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_value <= 6'd0;
    end else if (i_clear) begin
      o_value <= 6'd0;
    end else if (step) begin
      o_value <= next_value;
    end
  end

endmodule

`default_nettype wire

//--- src/display_top.sv
`include "display_defines.svh"
`default_nettype none

module display_top (
  input  wire logic                   i_clk,
  input  wire logic                   i_reset,
  input  wire logic                   i_cmd_valid,
  input  wire display_pkg::disp_cmd_t i_cmd,
  output logic                        o_credit,
  output display_pkg::seg_pair_t      o_segments
);

  logic [5:0]                  limit;
  logic [`DISP_PRESCALE_W-1:0] prescale;
  logic                        run;
  logic                        clear;
  logic [5:0]                  value;

  counter_config_regs u_config (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd       (i_cmd),
    .o_credit    (o_credit),
    .o_limit     (limit),
    .o_prescale  (prescale),
    .o_run       (run),
    .o_clear     (clear)
  );

  tick_counter u_counter (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_limit    (limit),
    .i_prescale (prescale),
    .i_run      (run),
    .i_clear    (clear),
    .o_value    (value)
  );

  seven_hex_decoder u_decoder (
    .i_value    (value),
    .o_segments (o_segments)
  );

endmodule

`default_nettype wire

//--- verif/display_sva.sv
`include "display_defines.svh"
`default_nettype none

module display_sva #(
  parameter bit CHECK_QUEUE = 1'b1
) (
  input wire logic                                   i_clk,
  input wire logic                                   i_reset,
  input wire logic [$clog2(`DISP_CMD_DEPTH + 1)-1:0] i_fill,
  input wire logic                                   i_clear,
  input wire logic [5:0]                             i_limit,
  input wire logic [5:0]                             i_value
);
  timeunit 1ns;
  timeprecision 1ps;

  if (CHECK_QUEUE) begin : g_queue
    fill_within_depth: assert property (@(posedge i_clk) disable iff (i_reset)
      i_fill <= `DISP_CMD_DEPTH)
      else $error("Command queue fill %0d is above its depth", i_fill);

    clear_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
      i_clear |=> !i_clear)
      else $error("Clear pulse stayed high for two cycles");
  end else begin : g_counter
    // A step taken under a settled limit lands at or below it.
    value_within_limit: assert property (@(posedge i_clk) disable iff (i_reset)
      ($stable(i_limit) && $changed(i_value)) |-> (i_value <= i_limit))
      else $error("Value %0d stepped above limit %0d", i_value, i_limit);
  end

endmodule

bind counter_config_regs display_sva #(.CHECK_QUEUE (1'b1)) u_config_sva (
  .i_clk (i_clk), .i_reset (i_reset), .i_fill (fill_count),
  .i_clear (o_clear), .i_limit (o_limit), .i_value (6'd0)
);

bind tick_counter display_sva #(.CHECK_QUEUE (1'b0)) u_counter_sva (
  .i_clk (i_clk), .i_reset (i_reset), .i_fill ('0),
  .i_clear (i_clear), .i_limit (i_limit), .i_value (o_value)
);

`default_nettype wire

//--- verif/display_tb.sv
`include "display_defines.svh"
`default_nettype none

module display_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import display_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int BURST_COUNT = 24;
  localparam int MAX_GAP     = 2;

  typedef struct {
    disp_cmd_t cmd;
    int        wait_cycles;
    int        exp_value;
  } step_t;

  logic      i_clk;
  logic      i_reset;
  logic      i_cmd_valid;
  disp_cmd_t i_cmd;
  logic      o_credit;
  seg_pair_t o_segments;

  step_t     steps[$];
  disp_cmd_t m_queue[$];
  int        m_value, m_pcount, m_limit, m_prescale;
  logic      m_run, m_clear, m_credit;
  int        credits, errors, checks;

  display_top UUT (
    .i_clk (i_clk), .i_reset (i_reset), .i_cmd_valid (i_cmd_valid),
    .i_cmd (i_cmd), .o_credit (o_credit), .o_segments (o_segments)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ********************
  // Reference model.
  function automatic logic [6:0] digit_pattern(input int digit);
    case (digit)
      0: return `DISP_SEG_D0;
      1: return `DISP_SEG_D1;
      2: return `DISP_SEG_D2;
      3: return `DISP_SEG_D3;
      4: return `DISP_SEG_D4;
      5: return `DISP_SEG_D5;
      6: return `DISP_SEG_D6;
      7: return `DISP_SEG_D7;
      8: return `DISP_SEG_D8;
      9: return `DISP_SEG_D9;
      default: return `DISP_SEG_BLANK;
    endcase
  endfunction

  function automatic seg_pair_t expected_segments(input int value);
    seg_pair_t seg;
    seg.tens = (value > `DISP_MAX_VALUE) ? `DISP_SEG_BLANK : digit_pattern(value / 10);
    seg.ones = (value > `DISP_MAX_VALUE) ? `DISP_SEG_BLANK : digit_pattern(value % 10);
    return seg;
  endfunction

  // The limit view sits in the low six bits of the payload.
  function automatic disp_cmd_t make_cmd(input cmd_op_e op, input int arg);
    disp_cmd_t cmd;
    cmd.op = op;
    cmd.payload.prescale = arg[`DISP_PRESCALE_W-1:0];
    return cmd;
  endfunction

  function automatic void add_step(input cmd_op_e op, input int arg, input int wait_cycles,
                                   input int exp_value);
    step_t s;
    s.cmd         = make_cmd(op, arg);
    s.wait_cycles = wait_cycles;
    s.exp_value   = exp_value;
    steps.push_back(s);
  endfunction

  function automatic void model_edge();
    disp_cmd_t head;
    int        lim;
    // The counter sees the configuration from before this edge.
    if (m_clear) begin
      m_value  = 0;
      m_pcount = 0;
    end else if (m_run && m_pcount == m_prescale) begin
      m_pcount = 0;
      m_value  = (m_value >= m_limit) ? 0 : m_value + 1;
    end else if (m_run) begin
      m_pcount++;
    end
    m_credit = 1'b0;
    m_clear  = 1'b0;
    if (m_queue.size() > 0) begin
      head     = m_queue.pop_front();
      m_credit = 1'b1;
      lim      = int'(head.payload.lim.limit);
      case (head.op)
        SET_LIMIT:    m_limit    = (lim > `DISP_MAX_VALUE) ? `DISP_MAX_VALUE : lim;
        SET_PRESCALE: m_prescale = int'(head.payload.prescale);
        RUN:          m_run      = 1'b1;
        STOP:         m_run      = 1'b0;
        CLEAR:        m_clear    = 1'b1;
        default:      ;
      endcase
    end
    if (i_cmd_valid) m_queue.push_back(i_cmd);
  endfunction

  // ********************
  // Checks and host.
  task automatic check_segments(input string name, input seg_pair_t expected,
                                input seg_pair_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0d ns: %s expected %b_%b, got %b_%b", $time, name,
               expected.tens, expected.ones, actual.tens, actual.ones);
    end
  endtask

  task automatic check_credit(input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0d ns: o_credit expected %b, got %b", $time, expected, actual);
    end
  endtask

  task automatic tick();
    @(posedge i_clk);
    model_edge();
    #2;
    check_credit(m_credit, o_credit);
    check_segments("o_segments", expected_segments(m_value), o_segments);
    if (o_credit === 1'b1) credits++;
    if (credits > `DISP_CMD_DEPTH) begin
      errors++;
      $display("Host holds %0d credits, more than the queue depth", credits);
    end
  endtask

  task automatic send_command(input disp_cmd_t cmd, input int wait_cycles, input int exp_value);
    while (credits == 0) tick();
    i_cmd_valid = 1'b1;
    i_cmd       = cmd;
    credits--;
    tick();
    i_cmd_valid = 1'b0;
    repeat (wait_cycles) tick();
    if (exp_value >= 0)
      check_segments("o_segments at step end", expected_segments(exp_value), o_segments);
  endtask

  task automatic watchdog(input int limit_ns);
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Done: errors found");
    $finish;
  endtask

  initial begin
    int        max_wait;
    int        pick;
    int        gap;
    disp_cmd_t cmd;
    i_reset = 1'b1;
    i_cmd_valid = 1'b0;
    i_cmd = '0;
    {errors, checks, max_wait} = '0;
    credits = `DISP_CMD_DEPTH;
    void'($urandom(46));
    // Op, argument, wait cycles, value shown at the end of the wait.
    add_step(SET_PRESCALE, 0, 2, 0);
    add_step(SET_LIMIT, 47, 2, 0);
    add_step(RUN, 0, 50, 1);
    add_step(SET_LIMIT, 60, 47, 1);
    add_step(SET_LIMIT, 9, 12, 4);
    add_step(STOP, 0, 4, 6);
    add_step(CLEAR, 0, 3, 0);
    add_step(SET_PRESCALE, 3, 2, 0);
    add_step(RUN, 0, 14, 3);
    add_step(STOP, 0, 6, 3);
    add_step(CLEAR, 0, 3, 0);
    add_step(SET_PRESCALE, 0, 2, 0);
    add_step(SET_LIMIT, 47, 2, 0);
    foreach (steps[i]) begin
      if (steps[i].wait_cycles > max_wait) begin
        max_wait = steps[i].wait_cycles;
      end
    end
    fork
      watchdog((steps.size() * (max_wait + 1) + BURST_COUNT * (MAX_GAP + 2) + 100) * CLK_PERIOD);
    join_none
    repeat (3) @(posedge i_clk);
    #2;
    i_reset = 1'b0;
    {m_value, m_pcount, m_prescale} = '0;
    m_limit = `DISP_MAX_VALUE;
    {m_run, m_clear, m_credit} = '0;
    repeat (4) tick();
    foreach (steps[i]) send_command(steps[i].cmd, steps[i].wait_cycles, steps[i].exp_value);
    for (int n = 0; n < BURST_COUNT; n++) begin
      pick = int'($urandom_range(3, 0));
      gap  = int'($urandom_range(MAX_GAP, 0));
      case (pick)
        0:       cmd = make_cmd(SET_LIMIT, int'($urandom_range(63, 0)));
        1:       cmd = make_cmd(SET_PRESCALE, 0);
        2:       cmd = make_cmd(RUN, 0);
        default: cmd = make_cmd(STOP, 0);
      endcase
      send_command(cmd, gap, -1);
    end
    repeat (4) tick();
    if (credits != `DISP_CMD_DEPTH) begin
      errors++;
      $display("Host ends with %0d credits instead of %0d", credits, `DISP_CMD_DEPTH);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+src
src/display_pkg.sv
src/seven_hex_decoder.sv
src/counter_config_regs.sv
src/tick_counter.sv
src/display_top.sv
verif/display_sva.sv
verif/display_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the display testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module display_tb -f filelist.f -o display_sim || exit 1
./obj_dir/display_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
exit 0
